/* src/serial_link_pkg.sv */
// **************************************************
// Shared widths, clock divider limits, APB register
// map and transmitter FSM states for the serial link
// **************************************************

package serial_link_pkg;

  // Stream and lane geometry
  localparam int unsigned WordWidth    = 32;
  localparam int unsigned NumLanes     = 8;
  localparam int unsigned BeatsPerWord = WordWidth / NumLanes;
  localparam int unsigned BeatCntWidth = 2;

  // Clock divider
  localparam int unsigned MaxClkDiv   = 1024;
  localparam int unsigned ClkDivWidth = 11;
  localparam int unsigned ClkDivReset = 4;

  // APB bus
  localparam int unsigned ApbAddrWidth = 8;
  localparam int unsigned ApbDataWidth = 32;

  // Register offsets
  typedef enum logic [ApbAddrWidth-1:0] {
    REG_CTRL       = 8'h00,
    REG_CLK_DIV    = 8'h04,
    REG_TX_COUNT   = 8'h08,
    REG_RX_COUNT   = 8'h0C,
    REG_DROP_COUNT = 8'h10
  } serial_link_reg_e;

  // Transmitter FSM
  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_e;

endpackage

/* src/serial_link_reg.sv */
// **************************************************
// APB register file: link enables, clock divider and
// the tx, rx and drop traffic counters
// **************************************************

`timescale 1ns/1ns

module serial_link_reg import serial_link_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    apb_psel_i,
  input  logic                    apb_penable_i,
  input  logic                    apb_pwrite_i,
  input  logic [ApbAddrWidth-1:0] apb_paddr_i,
  input  logic [ApbDataWidth-1:0] apb_pwdata_i,
  input  logic                    tx_word_accepted_i,
  input  logic                    rx_word_stored_i,
  input  logic                    rx_word_dropped_i,
  output logic [ApbDataWidth-1:0] apb_prdata_o,
  output logic                    apb_pready_o,
  output logic                    apb_pslverr_o,
  output logic                    tx_en_o,
  output logic                    rx_en_o,
  output logic [ClkDivWidth-1:0]  clk_div_o
);

  logic                    access;
  logic                    addr_valid;
  logic                    write;
  logic [ClkDivWidth-1:0]  clk_div_wdata;
  logic [ApbDataWidth-1:0] tx_count_q;
  logic [ApbDataWidth-1:0] rx_count_q;
  logic [ApbDataWidth-1:0] drop_count_q;
  logic                    tx_en_q;
  logic                    rx_en_q;
  logic [ClkDivWidth-1:0]  clk_div_q;

  assign access = apb_psel_i && apb_penable_i;
  assign write  = access && apb_pwrite_i && addr_valid;

  // Zero-wait slave
  assign apb_pready_o  = 1'b1;
  assign apb_pslverr_o = access && !addr_valid;

  // Address decode and read mux
  always_comb begin
    addr_valid   = 1'b1;
    apb_prdata_o = '0;
    case (apb_paddr_i)
      REG_CTRL: begin
        apb_prdata_o = {{(ApbDataWidth-2){1'b0}}, rx_en_q, tx_en_q};
      end
      REG_CLK_DIV: begin
        apb_prdata_o = ApbDataWidth'(clk_div_q);
      end
      REG_TX_COUNT: begin
        apb_prdata_o = tx_count_q;
      end
      REG_RX_COUNT: begin
        apb_prdata_o = rx_count_q;
      end
      REG_DROP_COUNT: begin
        apb_prdata_o = drop_count_q;
      end
      default: begin
        addr_valid = 1'b0;
      end
    endcase
  end

  // Divider writes land in 1..MaxClkDiv
  always_comb begin
    if (apb_pwdata_i == '0) begin
      clk_div_wdata = ClkDivWidth'(1);
    end else if (apb_pwdata_i > ApbDataWidth'(MaxClkDiv)) begin
      clk_div_wdata = ClkDivWidth'(MaxClkDiv);
    end else begin
      clk_div_wdata = apb_pwdata_i[ClkDivWidth-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_en_q   <= 1'b0;
      rx_en_q   <= 1'b0;
      clk_div_q <= ClkDivWidth'(ClkDivReset);
    end else if (write) begin
      if (apb_paddr_i == REG_CTRL) begin
        tx_en_q <= apb_pwdata_i[0];
        rx_en_q <= apb_pwdata_i[1];
      end
      if (apb_paddr_i == REG_CLK_DIV) begin
        clk_div_q <= clk_div_wdata;
      end
    end
  end

  // Traffic counters, free running and wrapping
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_count_q   <= '0;
      rx_count_q   <= '0;
      drop_count_q <= '0;
    end else begin
      if (tx_word_accepted_i) begin
        tx_count_q <= tx_count_q + 1'b1;
      end
      if (rx_word_stored_i) begin
        rx_count_q <= rx_count_q + 1'b1;
      end
      // A write clears, even against a drop in the same cycle
      if (write && apb_paddr_i == REG_DROP_COUNT) begin
        drop_count_q <= '0;
      end else if (rx_word_dropped_i) begin
        drop_count_q <= drop_count_q + 1'b1;
      end
    end
  end

  assign tx_en_o   = tx_en_q;
  assign rx_en_o   = rx_en_q;
  assign clk_div_o = clk_div_q;

endmodule

/* src/serial_link_tx.sv */
// **************************************************
// Link transmitter: takes stream words and sends them
// as lane beats at the divided rate
// **************************************************

`timescale 1ns/1ns

module serial_link_tx import serial_link_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   tx_en_i,
  input  logic [ClkDivWidth-1:0] clk_div_i,
  input  logic [WordWidth-1:0]   in_data_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output logic                   word_accepted_o,
  output logic [NumLanes-1:0]    lane_o,
  output logic                   lane_valid_o,
  output logic                   lane_sof_o
);

  localparam logic [BeatCntWidth-1:0] LastBeat = BeatCntWidth'(BeatsPerWord - 1);

  tx_state_e               state_q;
  tx_state_e               state_d;
  logic [WordWidth-1:0]    shift_q;
  logic [ClkDivWidth-1:0]  div_q;
  logic [ClkDivWidth-1:0]  tick_cnt_q;
  logic [BeatCntWidth-1:0] beat_cnt_q;
  logic                    accept;
  logic                    tick;

  // New words only while idle and enabled
  assign in_ready_o      = (state_q == TX_IDLE) && tx_en_i;
  assign accept          = in_valid_i && in_ready_o;
  assign word_accepted_o = accept;

  // One tick every div_q cycles while sending
  assign tick = (state_q == TX_SEND) && (tick_cnt_q == div_q);

  assign lane_valid_o = tick;
  assign lane_sof_o   = tick && (beat_cnt_q == '0);
  assign lane_o       = tick ? shift_q[NumLanes-1:0] : '0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      TX_IDLE: begin
        if (accept) begin
          state_d = TX_SEND;
        end
      end
      TX_SEND: begin
        // Finishes the word even if tx_en drops
        if (tick && (beat_cnt_q == LastBeat)) begin
          state_d = TX_IDLE;
        end
      end
      default: begin
        state_d = TX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= TX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Tick and beat counters
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tick_cnt_q <= '0;
      beat_cnt_q <= '0;
    end else begin
      if (accept) begin
        tick_cnt_q <= ClkDivWidth'(1);
        beat_cnt_q <= '0;
      end else if (tick) begin
        tick_cnt_q <= ClkDivWidth'(1);
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end else if (state_q == TX_SEND) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
    end
  end

  // Word and divider held for the whole word, LSB beat first
  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= in_data_i;
      div_q   <= clk_div_i;
    end else if (tick) begin
      shift_q <= shift_q >> NumLanes;
    end
  end

endmodule

/* src/serial_link_rx.sv */
// **************************************************
// Link receiver: rebuilds words from lane beats into
// a one-entry output buffer
// **************************************************

`timescale 1ns/1ns

module serial_link_rx import serial_link_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  rx_en_i,
  input  logic [NumLanes-1:0]   lane_i,
  input  logic                  lane_valid_i,
  input  logic                  lane_sof_i,
  input  logic                  out_ready_i,
  output logic [WordWidth-1:0]  out_data_o,
  output logic                  out_valid_o,
  output logic                  word_stored_o,
  output logic                  word_dropped_o
);

  localparam logic [BeatCntWidth-1:0] LastBeat = BeatCntWidth'(BeatsPerWord - 1);

  logic [WordWidth-1:0]    asm_q;
  logic [WordWidth-1:0]    word;
  logic [WordWidth-1:0]    out_data_q;
  logic [BeatCntWidth-1:0] beat_cnt_q;
  logic [BeatCntWidth-1:0] beat_idx;
  logic                    beat;
  logic                    word_done;
  logic                    buf_free;
  logic                    out_valid_q;

  // Beats count only while enabled
  assign beat     = lane_valid_i && rx_en_i;
  assign beat_idx = lane_sof_i ? '0 : beat_cnt_q;

  // Last beat goes on top of the assembled lower beats
  assign word      = {lane_i, asm_q[WordWidth-1:NumLanes]};
  assign word_done = beat && (beat_idx == LastBeat);

  // Buffer empty or drained on this edge
  assign buf_free       = !out_valid_q || out_ready_i;
  assign word_stored_o  = word_done && buf_free;
  assign word_dropped_o = word_done && !buf_free;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beat_cnt_q <= '0;
    end else if (beat) begin
      beat_cnt_q <= beat_idx + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat) begin
      asm_q <= {lane_i, asm_q[WordWidth-1:NumLanes]};
    end
  end

  // One-entry output buffer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (word_stored_o) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_stored_o) begin
      out_data_q <= word;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

endmodule

/* src/serial_link.sv */
// **************************************************
// Serial link top: register file, transmitter and
// receiver of a single channel
// **************************************************

`timescale 1ns/1ns

module serial_link import serial_link_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // APB slave
  input  logic                    apb_psel_i,
  input  logic                    apb_penable_i,
  input  logic                    apb_pwrite_i,
  input  logic [ApbAddrWidth-1:0] apb_paddr_i,
  input  logic [ApbDataWidth-1:0] apb_pwdata_i,
  output logic [ApbDataWidth-1:0] apb_prdata_o,
  output logic                    apb_pready_o,
  output logic                    apb_pslverr_o,
  // Input stream
  input  logic [WordWidth-1:0]    in_data_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  // Output stream
  output logic [WordWidth-1:0]    out_data_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  // Link
  output logic [NumLanes-1:0]     lane_o,
  output logic                    lane_valid_o,
  output logic                    lane_sof_o,
  input  logic [NumLanes-1:0]     lane_i,
  input  logic                    lane_valid_i,
  input  logic                    lane_sof_i
);

  logic                   tx_en;
  logic                   rx_en;
  logic [ClkDivWidth-1:0] clk_div;
  logic                   tx_word_accepted;
  logic                   rx_word_stored;
  logic                   rx_word_dropped;

  serial_link_reg i_reg (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .apb_psel_i         ( apb_psel_i       ),
    .apb_penable_i      ( apb_penable_i    ),
    .apb_pwrite_i       ( apb_pwrite_i     ),
    .apb_paddr_i        ( apb_paddr_i      ),
    .apb_pwdata_i       ( apb_pwdata_i     ),
    .tx_word_accepted_i ( tx_word_accepted ),
    .rx_word_stored_i   ( rx_word_stored   ),
    .rx_word_dropped_i  ( rx_word_dropped  ),
    .apb_prdata_o       ( apb_prdata_o     ),
    .apb_pready_o       ( apb_pready_o     ),
    .apb_pslverr_o      ( apb_pslverr_o    ),
    .tx_en_o            ( tx_en            ),
    .rx_en_o            ( rx_en            ),
    .clk_div_o          ( clk_div          )
  );

  serial_link_tx i_tx (
    .clk_i           ( clk_i            ),
    .rst_n_i         ( rst_n_i          ),
    .tx_en_i         ( tx_en            ),
    .clk_div_i       ( clk_div          ),
    .in_data_i       ( in_data_i        ),
    .in_valid_i      ( in_valid_i       ),
    .in_ready_o      ( in_ready_o       ),
    .word_accepted_o ( tx_word_accepted ),
    .lane_o          ( lane_o           ),
    .lane_valid_o    ( lane_valid_o     ),
    .lane_sof_o      ( lane_sof_o       )
  );

  serial_link_rx i_rx (
    .clk_i          ( clk_i           ),
    .rst_n_i        ( rst_n_i         ),
    .rx_en_i        ( rx_en           ),
    .lane_i         ( lane_i          ),
    .lane_valid_i   ( lane_valid_i    ),
    .lane_sof_i     ( lane_sof_i      ),
    .out_ready_i    ( out_ready_i     ),
    .out_data_o     ( out_data_o      ),
    .out_valid_o    ( out_valid_o     ),
    .word_stored_o  ( rx_word_stored  ),
    .word_dropped_o ( rx_word_dropped )
  );

endmodule

/* bench/serial_link_tb.sv */
// **************************************************
// Loopback testbench: stimulus table, APB and stream
// tasks, output word and lane monitors, watchdog
// **************************************************

`timescale 1ns/1ns

module serial_link_tb import serial_link_pkg::*; ();

  localparam int ClkPeriod  = 40;
  localparam int DriveDelay = 5;
  localparam int WaitLimit  = 4 * MaxClkDiv + 20;
  localparam logic [ApbAddrWidth-1:0] NoAddr  = 8'h00;
  localparam logic [ApbAddrWidth-1:0] BadAddr = 8'h14;

  typedef enum int {
    OP_WRITE, OP_READ, OP_BAD, OP_SEND, OP_SEND_LOST,
    OP_EXPECT, OP_PEEK, OP_READY, OP_DRAIN, OP_QUIET
  } op_e;

  logic                    clk;
  logic                    rst_n;
  logic                    apb_psel;
  logic                    apb_penable;
  logic                    apb_pwrite;
  logic [ApbAddrWidth-1:0] apb_paddr;
  logic [ApbDataWidth-1:0] apb_pwdata;
  logic [ApbDataWidth-1:0] apb_prdata;
  logic                    apb_pready;
  logic                    apb_pslverr;
  logic [WordWidth-1:0]    in_data;
  logic                    in_valid;
  logic                    in_ready;
  logic [WordWidth-1:0]    out_data;
  logic                    out_valid;
  logic                    out_ready;
  logic [NumLanes-1:0]     lane;
  logic                    lane_valid;
  logic                    lane_sof;

  // Stimulus table, one entry per test
  string                   t_name[$];
  op_e                     t_op[$];
  logic [ApbAddrWidth-1:0] t_addr[$];
  logic [WordWidth-1:0]    t_data[$];
  logic [WordWidth-1:0]    t_exp[$];

  logic [WordWidth-1:0]    exp_q[$];
  string                   cur_name;
  integer                  seed;
  int                      error_count;
  int                      tests_passed;
  int                      tests_failed;
  int                      lane_div;
  logic                    table_ready;

  // Lanes looped back from output to input
  serial_link dut_i (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .apb_psel_i    ( apb_psel    ),
    .apb_penable_i ( apb_penable ),
    .apb_pwrite_i  ( apb_pwrite  ),
    .apb_paddr_i   ( apb_paddr   ),
    .apb_pwdata_i  ( apb_pwdata  ),
    .apb_prdata_o  ( apb_prdata  ),
    .apb_pready_o  ( apb_pready  ),
    .apb_pslverr_o ( apb_pslverr ),
    .in_data_i     ( in_data     ),
    .in_valid_i    ( in_valid    ),
    .in_ready_o    ( in_ready    ),
    .out_data_o    ( out_data    ),
    .out_valid_o   ( out_valid   ),
    .out_ready_i   ( out_ready   ),
    .lane_o        ( lane        ),
    .lane_valid_o  ( lane_valid  ),
    .lane_sof_o    ( lane_sof    ),
    .lane_i        ( lane        ),
    .lane_valid_i  ( lane_valid  ),
    .lane_sof_i    ( lane_sof    )
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk = ~clk;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic add_entry(input string name, input op_e op, input logic [7:0] addr,
                           input logic [31:0] data, input logic [31:0] exp);
    t_name.push_back(name);
    t_op.push_back(op);
    t_addr.push_back(addr);
    t_data.push_back(data);
    t_exp.push_back(exp);
  endtask

  task automatic add_send(input string name, input bit arrives);
    logic [WordWidth-1:0] word;
    word = $random(seed);
    if (arrives) begin
      add_entry(name, OP_SEND, NoAddr, word, word);
    end else begin
      add_entry(name, OP_SEND_LOST, NoAddr, word, word);
    end
  endtask

  task automatic build_table();
    int divs [3];
    divs = '{1, 4, 7};
    add_entry("rst_ctrl", OP_READ, REG_CTRL, 0, 0);
    add_entry("rst_clk_div", OP_READ, REG_CLK_DIV, 0, 4);
    add_entry("rst_tx_count", OP_READ, REG_TX_COUNT, 0, 0);
    add_entry("rst_rx_count", OP_READ, REG_RX_COUNT, 0, 0);
    add_entry("rst_drop_count", OP_READ, REG_DROP_COUNT, 0, 0);
    add_entry("rst_streams_idle", OP_QUIET, NoAddr, 16, 0);
    // Divider writes carry the value they should leave behind
    add_entry("div_write_zero", OP_WRITE, REG_CLK_DIV, 0, 1);
    add_entry("div_read_one", OP_READ, REG_CLK_DIV, 0, 1);
    add_entry("div_write_2000", OP_WRITE, REG_CLK_DIV, 2000, 1024);
    add_entry("div_read_max", OP_READ, REG_CLK_DIV, 0, 1024);
    add_entry("out_ready_on", OP_READY, NoAddr, 1, 0);
    add_entry("enable_both", OP_WRITE, REG_CTRL, 3, 0);
    for (int d = 0; d < 3; d++) begin
      add_entry($sformatf("div%0d_write", divs[d]), OP_WRITE, REG_CLK_DIV, divs[d], divs[d]);
      for (int k = 0; k < 3; k++) begin
        add_send($sformatf("div%0d_send%0d", divs[d], k), 1'b1);
      end
      add_entry($sformatf("div%0d_receive", divs[d]), OP_EXPECT, NoAddr, 0, 0);
    end
    add_entry("loop_tx_count", OP_READ, REG_TX_COUNT, 0, 9);
    add_entry("loop_rx_count", OP_READ, REG_RX_COUNT, 0, 9);
    // Back-pressure keeps the first word and drops the next two
    add_entry("bp_ready_off", OP_READY, NoAddr, 0, 0);
    add_send("bp_send_kept", 1'b1);
    add_send("bp_send_drop0", 1'b0);
    add_send("bp_send_drop1", 1'b0);
    add_entry("bp_tx_done", OP_DRAIN, NoAddr, 0, 0);
    add_entry("bp_word_held", OP_PEEK, NoAddr, 0, 0);
    add_entry("bp_drop_count", OP_READ, REG_DROP_COUNT, 0, 2);
    add_entry("bp_rx_count", OP_READ, REG_RX_COUNT, 0, 10);
    add_entry("bp_tx_count", OP_READ, REG_TX_COUNT, 0, 12);
    // Bad address must not touch enables, divider or a nonzero drop count
    add_entry("bad_addr", OP_BAD, BadAddr, 32'h0000_0000, 0);
    add_entry("bad_keeps_ctrl", OP_READ, REG_CTRL, 0, 3);
    add_entry("bad_keeps_clk_div", OP_READ, REG_CLK_DIV, 0, 7);
    add_entry("bad_keeps_drop", OP_READ, REG_DROP_COUNT, 0, 2);
    add_entry("bp_ready_on", OP_READY, NoAddr, 1, 0);
    add_entry("bp_receive", OP_EXPECT, NoAddr, 0, 0);
    add_entry("bp_drop_clear", OP_WRITE, REG_DROP_COUNT, 32'hffff_ffff, 0);
    add_entry("bp_drop_cleared", OP_READ, REG_DROP_COUNT, 0, 0);
    // Receiver disabled, then transmitter disabled
    add_entry("rx_off", OP_WRITE, REG_CTRL, 1, 0);
    add_send("rx_off_send", 1'b0);
    add_entry("rx_off_tx_done", OP_DRAIN, NoAddr, 0, 0);
    add_entry("rx_off_no_word", OP_QUIET, NoAddr, 16, 1);
    add_entry("rx_off_rx_count", OP_READ, REG_RX_COUNT, 0, 10);
    add_entry("rx_off_tx_count", OP_READ, REG_TX_COUNT, 0, 13);
    add_entry("tx_off", OP_WRITE, REG_CTRL, 2, 0);
    add_entry("tx_off_not_ready", OP_QUIET, NoAddr, 16, 0);
  endtask

  task automatic step();
    @(posedge clk);
    #(DriveDelay);
  endtask

  // Setup and access phase; the access edge ends the transfer
  task automatic apb_access(input logic wr, input logic [ApbAddrWidth-1:0] addr,
                            input logic [ApbDataWidth-1:0] wdata,
                            output logic [ApbDataWidth-1:0] rdata,
                            output logic slverr, output logic ready);
    step();
    apb_psel    = 1'b1;
    apb_penable = 1'b0;
    apb_pwrite  = wr;
    apb_paddr   = addr;
    apb_pwdata  = wdata;
    step();
    apb_penable = 1'b1;
    @(negedge clk);
    rdata  = apb_prdata;
    slverr = apb_pslverr;
    ready  = apb_pready;
    step();
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b0;
  endtask

  task automatic send_word(input logic [WordWidth-1:0] word);
    int cycles;
    cycles = 0;
    step();
    in_data  = word;
    in_valid = 1'b1;
    @(negedge clk);
    while (!in_ready && cycles < WaitLimit) begin
      cycles++;
      @(negedge clk);
    end
    if (!in_ready) begin
      $display("Error: %s: the transmitter never accepted the word", cur_name);
      error_count++;
    end
    step();
    in_valid = 1'b0;
  endtask

  task automatic wait_tx_idle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!in_ready && cycles < WaitLimit) begin
      cycles++;
      @(negedge clk);
    end
    if (!in_ready) begin
      $display("Error: %s: the transmitter did not return to idle", cur_name);
      error_count++;
    end
  endtask

  task automatic wait_words_drained();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (exp_q.size() != 0 && cycles < WaitLimit) begin
      cycles++;
      @(negedge clk);
    end
    if (exp_q.size() != 0) begin
      $display("Error: %s: %0d sent words never arrived", cur_name, exp_q.size());
      error_count++;
    end
  endtask

  task automatic watch_quiet(input int cycles, input logic ready_exp);
    repeat (cycles) begin
      @(negedge clk);
      check_value({cur_name, " in_ready"}, 32'(ready_exp), 32'(in_ready));
      check_value({cur_name, " out_valid"}, 32'd0, 32'(out_valid));
    end
  endtask

  // Each word taken from the output must be the oldest one outstanding
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Error: %s: a word left the link with none outstanding", cur_name);
          error_count++;
        end else begin
          check_value(cur_name, exp_q.pop_front(), out_data);
        end
      end
    end
  end

  // Beat k comes (k+1) divider periods after acceptance, sof on beat 0 only
  initial begin
    int since;
    int word_div;
    int beat_no;
    since    = 0;
    word_div = 0;
    beat_no  = 0;
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        check_value({cur_name, " reset lanes"}, 32'd0, 32'({lane_valid, lane_sof, lane}));
      end else begin
        since++;
        if (lane_valid) begin
          check_value({cur_name, " lane_sof"}, 32'(beat_no == 0), 32'(lane_sof));
          check_value({cur_name, " beat time"}, word_div * (beat_no + 1), since);
          beat_no = (beat_no + 1) % 4;
        end
        if (in_valid && in_ready) begin
          since    = 0;
          word_div = lane_div;
        end
      end
    end
  end

  initial begin
    int unsigned budget;
    wait (table_ready);
    budget = (32'(t_name.size()) * WaitLimit + 8) * ClkPeriod;
    #(budget);
    $display("Watchdog: the tests ran past their budget of %0d ns", budget);
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic [ApbDataWidth-1:0] rdata;
    logic                    slverr;
    logic                    ready;
    int                      errs_before;
    rst_n        = 1'b0;
    apb_psel     = 1'b0;
    apb_penable  = 1'b0;
    apb_pwrite   = 1'b0;
    apb_paddr    = '0;
    apb_pwdata   = '0;
    in_data      = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    lane_div     = 4;
    cur_name     = "reset";
    table_ready  = 1'b0;
    seed         = 32'hed91904b;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    #(DriveDelay);
    rst_n = 1'b1;
    for (int i = 0; i < t_name.size(); i++) begin
      cur_name    = t_name[i];
      errs_before = error_count;
      case (t_op[i])
        OP_WRITE: begin
          apb_access(1'b1, t_addr[i], t_data[i], rdata, slverr, ready);
          check_value({cur_name, " pready"}, 32'd1, 32'(ready));
          check_value({cur_name, " pslverr"}, 32'd0, 32'(slverr));
          if (t_addr[i] == REG_CLK_DIV) begin
            lane_div = int'(t_exp[i]);
          end
        end
        OP_READ: begin
          apb_access(1'b0, t_addr[i], '0, rdata, slverr, ready);
          check_value(cur_name, t_exp[i], rdata);
          check_value({cur_name, " pslverr"}, 32'd0, 32'(slverr));
        end
        OP_BAD: begin
          apb_access(1'b1, t_addr[i], t_data[i], rdata, slverr, ready);
          check_value({cur_name, " write pslverr"}, 32'd1, 32'(slverr));
          apb_access(1'b0, t_addr[i], '0, rdata, slverr, ready);
          check_value({cur_name, " read pslverr"}, 32'd1, 32'(slverr));
        end
        OP_SEND: begin
          exp_q.push_back(t_exp[i]);
          send_word(t_data[i]);
        end
        OP_SEND_LOST: send_word(t_data[i]);
        OP_EXPECT: wait_words_drained();
        OP_PEEK: begin
          @(negedge clk);
          check_value({cur_name, " out_valid"}, 32'd1, 32'(out_valid));
          if (exp_q.size() == 0) begin
            $display("Error: %s: no word is outstanding to compare with", cur_name);
            error_count++;
          end else begin
            check_value(cur_name, exp_q[0], out_data);
          end
        end
        OP_READY: begin
          step();
          out_ready = t_data[i][0];
        end
        OP_DRAIN: wait_tx_idle();
        OP_QUIET: watch_quiet(int'(t_data[i]), t_exp[i][0]);
        default: begin
          $display("Error: %s: unknown table operation", cur_name);
          error_count++;
        end
      endcase
      if (error_count == errs_before) begin
        tests_passed++;
        $display("Test %0d %s: ok", i, cur_name);
      end else begin
        tests_failed++;
        $display("Test %0d %s: %0d error(s)", i, cur_name, error_count - errs_before);
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             t_name.size(), tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* all.f */
src/serial_link_pkg.sv
src/serial_link_reg.sv
src/serial_link_tx.sv
src/serial_link_rx.sv
src/serial_link.sv
bench/serial_link_tb.sv

/* run.sh */
#!/bin/sh
# Builds the serial link testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module serial_link_tb \
  --Mdir obj_dir -o sim_serial_link
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_serial_link)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
